// ==== verilog/harness_defs.svh ====
`ifndef HARNESS_DEFS_SVH
`define HARNESS_DEFS_SVH

// bus word and byte lane widths
`define WORD_W       32
`define SEL_W        4

// word buffer between loader and master
`define FIFO_DEPTH   4
`define FIFO_AW      2

// serial loader bit counter, wraps after one full word
`define BIT_CNT_W    5

// first write address after reset, then one word per write
`define WB_BASE_ADDR 32'h0000_1000
`define ADDR_STEP    32'd4

`endif

// ==== verilog/wb_pkg.sv ====
`include "harness_defs.svh"

package wb_pkg;

   // outputs of a classic wishbone write master
   // 71 bits, cyc in the msb
   typedef struct packed {
      // bus cycle in progress
      logic               cyc;
      // strobe, one transfer
      logic               stb;
      // write enable, always high here
      logic               we;
      // byte lanes, all four written
      logic [`SEL_W-1:0]  sel;
      // byte address, word aligned
      logic [`WORD_W-1:0] adr;
      // write data
      logic [`WORD_W-1:0] dat;
   } wb_req_t;

endpackage

// ==== verilog/harness_pkg.sv ====
`include "harness_defs.svh"

package harness_pkg;

   // one bus word, read as a whole or lane by lane
   // byte 0 sits in bits 7..0
   typedef union packed {
      // whole word view, used by loader, fifo and master
      logic [`WORD_W-1:0]                  word;
      // byte view, used by the fold trees
      logic [`SEL_W-1:0][`WORD_W/`SEL_W-1:0] bytes;
   } bus_word_u;

   // compressed view of one 32-bit bus
   typedef struct packed {
      // first level, xor of the four bytes
      logic [7:0] fold8;
      // second level, pair xor then and-reduce
      logic       fold1;
   } fold_t;

endpackage

// ==== verilog/serial_word_loader.sv ====
`include "harness_defs.svh"
`timescale 1ns/100ps

module serial_word_loader import harness_pkg::*; (
   input  logic      CLK_I,
   input  logic      rst_n,
   input  logic      ser_din,
   input  logic      ser_en,
   output logic      word_valid,
   output bus_word_u word
);

   // bits collected so far, newest in bit 0
   logic [`WORD_W-1:0]    shift_q;
   // position inside the current word
   logic [`BIT_CNT_W-1:0] bit_cnt_q;
   logic                  valid_q;

   // shift register, payload only
   always_ff @(posedge CLK_I) begin
      if (ser_en) begin
         // first bit of a word ends up in bit 31
         shift_q <= {shift_q[`WORD_W-2:0], ser_din};
      end
   end

   // bit counter and the word strobe
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         bit_cnt_q <= '0;
         valid_q   <= 1'b0;
      end else begin
         // strobe only on the clock after the 32nd bit
         valid_q <= ser_en && (&bit_cnt_q);
         if (ser_en) begin
            // wraps from 31 back to 0 by itself
            bit_cnt_q <= bit_cnt_q + 1'b1;
         end
      end
   end

   assign word_valid = valid_q;
   // complete word held while valid is high
   assign word.word  = shift_q;

   // at least 32 enabled cycles between two words
   a_valid_single : assert property (
      @(posedge CLK_I) disable iff (!rst_n)
      word_valid |=> !word_valid
   );

endmodule

// ==== verilog/word_fifo.sv ====
`include "harness_defs.svh"
`timescale 1ns/100ps

module word_fifo import harness_pkg::*; (
   input  logic      CLK_I,
   input  logic      rst_n,
   input  logic      push,
   input  bus_word_u push_word,
   input  logic      pop,
   output bus_word_u head_word,
   output logic      empty,
   output logic      overflow
);

   // storage, no reset needed
   bus_word_u            mem [`FIFO_DEPTH];
   logic [`FIFO_AW-1:0]  wr_ptr_q;
   logic [`FIFO_AW-1:0]  rd_ptr_q;
   // one bit wider than the pointers
   logic [`FIFO_AW:0]    count_q;
   logic                 overflow_q;
   logic                 full;
   logic                 do_push;
   logic                 do_pop;

   assign full  = (count_q == `FIFO_DEPTH);
   assign empty = (count_q == '0);

   // pop frees a slot in the same cycle
   assign do_pop  = pop && !empty;
   assign do_push = push && (!full || do_pop);

   // write port
   always_ff @(posedge CLK_I) begin
      if (do_push) begin
         mem[wr_ptr_q] <= push_word;
      end
   end

   // pointers, count and sticky overflow
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_q <= 1'b0;
      end else begin
         // pointers wrap at depth 4
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         // dropped word, held until reset
         if (push && !do_push) begin
            overflow_q <= 1'b1;
         end
      end
   end

   // head visible one cycle after the push
   assign head_word = mem[rd_ptr_q];
   assign overflow  = overflow_q;

   // master only pops what it saw in the buffer
   a_no_pop_empty : assert property (
      @(posedge CLK_I) disable iff (!rst_n)
      pop |-> !empty
   );

   a_count_bound : assert property (
      @(posedge CLK_I) disable iff (!rst_n)
      count_q <= `FIFO_DEPTH
   );

endmodule

// ==== verilog/wb_write_master.sv ====
`include "harness_defs.svh"
`timescale 1ns/100ps

module wb_write_master import wb_pkg::*, harness_pkg::*; (
   input  logic      CLK_I,
   input  logic      rst_n,
   input  logic      empty,
   input  bus_word_u head_word,
   input  logic      ACK_I,
   output logic      pop,
   output wb_req_t   req
);

   // fsm encoding
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_POP   = 2'd1;
   localparam logic [1:0] ST_WRITE = 2'd2;

   logic [1:0]         state_q;
   // next write address
   logic [`WORD_W-1:0] addr_q;
   // request register, folds see zero until the first write
   wb_req_t            req_q;

   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         state_q <= ST_IDLE;
         addr_q  <= `WB_BASE_ADDR;
         req_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               // at least one idle cycle between writes
               if (!empty) begin
                  state_q <= ST_POP;
               end
            end
            ST_POP: begin
               // head word taken on this edge
               state_q   <= ST_WRITE;
               req_q.cyc <= 1'b1;
               req_q.stb <= 1'b1;
               req_q.we  <= 1'b1;
               req_q.sel <= '1;
               req_q.adr <= addr_q;
               req_q.dat <= head_word.word;
            end
            ST_WRITE: begin
               // ack only counts with stb up
               if (req_q.stb && ACK_I) begin
                  state_q   <= ST_IDLE;
                  req_q.cyc <= 1'b0;
                  req_q.stb <= 1'b0;
                  req_q.we  <= 1'b0;
                  addr_q    <= addr_q + `ADDR_STEP;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // one-cycle pop, fifo is non-empty here
   assign pop = (state_q == ST_POP);
   assign req = req_q;

   // slave may wait any number of cycles on a stable request
   a_req_stable : assert property (
      @(posedge CLK_I) disable iff (!rst_n)
      (req.stb && !ACK_I) |=> (req.stb && $stable(req.adr) && $stable(req.dat))
   );

endmodule

// ==== verilog/xor_fold_observer.sv ====
`timescale 1ns/100ps

module xor_fold_observer import harness_pkg::*; (
   input  logic      CLK_I,
   input  logic      rst_n,
   input  bus_word_u adr,
   input  bus_word_u dat,
   output fold_t     adr_fold,
   output fold_t     dat_fold
);

   fold_t adr_fold_q;
   fold_t dat_fold_q;

   // first level, xor of the four byte lanes
   function automatic logic [7:0] fold_bytes(input bus_word_u w);
      return w.bytes[3] ^ w.bytes[2] ^ w.bytes[1] ^ w.bytes[0];
   endfunction

   // second level, xor of bit pairs then and of the two bits
   function automatic logic fold_pairs(input logic [7:0] f);
      logic [1:0] pair_x;
      pair_x = f[7:6] ^ f[5:4] ^ f[3:2] ^ f[1:0];
      return &pair_x;
   endfunction

   // stage 1 feeds fold8, stage 2 reads stage 1
   // so two bus values can be in flight
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         adr_fold_q <= '0;
         dat_fold_q <= '0;
      end else begin
         // stage 1
         adr_fold_q.fold8 <= fold_bytes(adr);
         dat_fold_q.fold8 <= fold_bytes(dat);
         // stage 2, two cycles after the bus
         adr_fold_q.fold1 <= fold_pairs(adr_fold_q.fold8);
         dat_fold_q.fold1 <= fold_pairs(dat_fold_q.fold8);
      end
   end

   // 64 bus bits down to 18 pins
   assign adr_fold = adr_fold_q;
   assign dat_fold = dat_fold_q;

endmodule

// ==== verilog/pinreduce_top.sv ====
`include "harness_defs.svh"
`timescale 1ns/100ps

module pinreduce_top import wb_pkg::*, harness_pkg::*; (
   input  logic              CLK_I,
   input  logic              rst_n,
   input  logic              ser_din,
   input  logic              ser_en,
   input  logic              ACK_I,
   output logic              CYC_O,
   output logic              STB_O,
   output logic              WE_O,
   output logic [`SEL_W-1:0] SEL_O,
   output fold_t             adr_fold,
   output fold_t             dat_fold,
   output logic              overflow
);

   // loader to fifo
   logic      word_valid;
   bus_word_u word;
   // fifo to master
   bus_word_u head_word;
   logic      empty;
   logic      pop;
   // master request, wide buses only reach the folds
   wb_req_t   req;

   serial_word_loader i_loader (
      .CLK_I      (CLK_I),
      .rst_n      (rst_n),
      .ser_din    (ser_din),
      .ser_en     (ser_en),
      .word_valid (word_valid),
      .word       (word)
   );

   // input never stalls, overflow drops words
   word_fifo i_fifo (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .push      (word_valid),
      .push_word (word),
      .pop       (pop),
      .head_word (head_word),
      .empty     (empty),
      .overflow  (overflow)
   );

   wb_write_master i_master (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .empty     (empty),
      .head_word (head_word),
      .ACK_I     (ACK_I),
      .pop       (pop),
      .req       (req)
   );

   xor_fold_observer i_observer (
      .CLK_I    (CLK_I),
      .rst_n    (rst_n),
      .adr      (req.adr),
      .dat      (req.dat),
      .adr_fold (adr_fold),
      .dat_fold (dat_fold)
   );

   // narrow control pins straight from the request
   assign CYC_O = req.cyc;
   assign STB_O = req.stb;
   assign WE_O  = req.we;
   assign SEL_O = req.sel;

endmodule

// ==== bench/tb_pinreduce.sv ====
`include "harness_defs.svh"
`timescale 1ns/100ps

module tb_pinreduce import harness_pkg::*; ();

   // longest random ser_en gap inside one word
   localparam int MAX_GAP  = 7;
   localparam int MAX_RECS = 32;
   // cycles that must stay quiet after the burst
   localparam int QUIET    = 10;

   logic              CLK_I;
   logic              rst_n;
   logic              ser_din;
   logic              ser_en;
   logic              ACK_I;
   logic              CYC_O;
   logic              STB_O;
   logic              WE_O;
   logic [`SEL_W-1:0] SEL_O;
   fold_t             adr_fold;
   fold_t             dat_fold;
   logic              overflow;

   // records from the stimulus file
   int          rec_id    [MAX_RECS];
   logic [31:0] rec_word  [MAX_RECS];
   int          rec_ack   [MAX_RECS];
   logic [7:0]  rec_af8   [MAX_RECS];
   logic        rec_af1   [MAX_RECS];
   logic [7:0]  rec_df8   [MAX_RECS];
   logic        rec_df1   [MAX_RECS];
   logic        rec_burst [MAX_RECS];
   int          n_recs;
   logic        file_ovf;

   // reference model of the words in bus order
   logic [31:0] sent_q[$];
   int          idx_q[$];
   logic [31:0] exp_addr;
   int          last_idx;
   logic [31:0] rng_state;

   int unsigned cycle_cnt;
   int unsigned cycle_limit;

   initial CLK_I = 1'b0;
   always #50 CLK_I = ~CLK_I;

   pinreduce_top i_dut (
      .CLK_I    (CLK_I),
      .rst_n    (rst_n),
      .ser_din  (ser_din),
      .ser_en   (ser_en),
      .ACK_I    (ACK_I),
      .CYC_O    (CYC_O),
      .STB_O    (STB_O),
      .WE_O     (WE_O),
      .SEL_O    (SEL_O),
      .adr_fold (adr_fold),
      .dat_fold (dat_fold),
      .overflow (overflow)
   );

   // xorshift32 step
   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // first level xors all four byte lanes
   function automatic logic [7:0] byte_fold(input logic [31:0] w);
      return w[31:24] ^ w[23:16] ^ w[15:8] ^ w[7:0];
   endfunction

   // second level xors the bit pairs down to two bits and needs both set
   function automatic logic pair_fold(input logic [7:0] f);
      logic [1:0] p;
      p = f[7:6] ^ f[5:4] ^ f[3:2] ^ f[1:0];
      return p[1] & p[0];
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         stop_with_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                     name, actual, expected));
      end
   endtask

   // line tags are w for a single write and b for a burst with ACK_I low
   // o carries the expected overflow and # starts a comment line
   task automatic load_stimulus;
      int            fd;
      int            code;
      logic [63:0]   tag;
      logic [1023:0] line_buf;
      int            t_id;
      int            t_ack;
      logic [31:0]   t_word;
      logic [7:0]    t_af8;
      logic [7:0]    t_af1;
      logic [7:0]    t_df8;
      logic [7:0]    t_df1;
      logic [7:0]    t_ovf;
      logic          done;
      logic          saw_ovf;
      n_recs  = 0;
      done    = 1'b0;
      saw_ovf = 1'b0;
      fd = $fopen("bench/pinreduce_stimulus.txt", "r");
      if (fd == 0) begin
         stop_with_failure("could not open bench/pinreduce_stimulus.txt");
      end else begin
         while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
               done = 1'b1;
            end else if (tag == "#") begin
               // skip rest of comment line
               code = $fgets(line_buf, fd);
            end else if (tag == "w" || tag == "b") begin
               code = $fscanf(fd, "%d %h %d %h %h %h %h", t_id, t_word, t_ack,
                              t_af8, t_af1, t_df8, t_df1);
               if (code != 7) begin
                  stop_with_failure("a word line in the stimulus file is malformed");
               end else if (t_ack < 1) begin
                  stop_with_failure("an ack wait in the stimulus file is below one cycle");
               end else if (n_recs >= MAX_RECS) begin
                  stop_with_failure("the stimulus file holds too many words");
               end else begin
                  rec_id[n_recs]    = t_id;
                  rec_word[n_recs]  = t_word;
                  rec_ack[n_recs]   = t_ack;
                  rec_af8[n_recs]   = t_af8;
                  rec_af1[n_recs]   = t_af1[0];
                  rec_df8[n_recs]   = t_df8;
                  rec_df1[n_recs]   = t_df1[0];
                  rec_burst[n_recs] = (tag == "b");
                  n_recs = n_recs + 1;
               end
            end else if (tag == "o") begin
               code = $fscanf(fd, "%h", t_ovf);
               file_ovf = t_ovf[0];
               saw_ovf  = 1'b1;
            end else begin
               stop_with_failure("the stimulus file has a line with an unknown tag");
            end
         end
         $fclose(fd);
         if (!saw_ovf) begin
            stop_with_failure("the stimulus file has no overflow line");
         end
      end
   endtask

   // msb first with one random ser_en gap somewhere in the word
   task automatic send_word(input logic [31:0] w);
      int gap;
      int gap_pos;
      int b;
      int g;
      rng_state = next_random(rng_state);
      gap       = rng_state % (MAX_GAP + 1);
      gap_pos   = (rng_state >> 8) % 32;
      for (b = 0; b < 32; b++) begin
         if (b == gap_pos) begin
            for (g = 0; g < gap; g++) begin
               // junk on ser_din that the loader must ignore
               rng_state = next_random(rng_state);
               ser_en    = 1'b0;
               ser_din   = rng_state[0];
               @(negedge CLK_I);
            end
         end
         ser_en  = 1'b1;
         ser_din = w[31-b];
         @(negedge CLK_I);
      end
      ser_en  = 1'b0;
      ser_din = 1'b0;
   endtask

   // one write from the strobe through the ack until the strobe drops
   task automatic serve_write;
      logic [31:0] w;
      logic [31:0] a;
      int          idx;
      int          c;
      int          last_c;
      string       sfx;
      while (STB_O !== 1'b1) begin
         @(negedge CLK_I);
      end
      w   = sent_q.pop_front();
      idx = idx_q.pop_front();
      a   = exp_addr;
      sfx = $sformatf(" of test %0d", rec_id[idx]);
      check_value({"CYC_O", sfx}, CYC_O, 1'b1);
      check_value({"WE_O", sfx}, WE_O, 1'b1);
      check_value({"SEL_O", sfx}, SEL_O, {`SEL_W{1'b1}});
      // file folds must agree with the model
      check_value({"file adr_fold8", sfx}, rec_af8[idx], byte_fold(a));
      check_value({"file adr_fold1", sfx}, rec_af1[idx], pair_fold(byte_fold(a)));
      check_value({"file dat_fold8", sfx}, rec_df8[idx], byte_fold(w));
      check_value({"file dat_fold1", sfx}, rec_df1[idx], pair_fold(byte_fold(w)));
      last_c = (rec_ack[idx] + 1 > 2) ? rec_ack[idx] + 1 : 2;
      for (c = 1; c <= last_c; c++) begin
         @(negedge CLK_I);
         // high while withheld and low right after the ack edge
         check_value({"STB_O", sfx}, STB_O, (c <= rec_ack[idx]));
         if (c >= 2) begin
            // folds settled two cycles after the strobe
            check_value({"adr_fold.fold8", sfx}, adr_fold.fold8, rec_af8[idx]);
            check_value({"adr_fold.fold1", sfx}, adr_fold.fold1, rec_af1[idx]);
            check_value({"dat_fold.fold8", sfx}, dat_fold.fold8, rec_df8[idx]);
            check_value({"dat_fold.fold1", sfx}, dat_fold.fold1, rec_df1[idx]);
         end
         ACK_I = (c == rec_ack[idx]);
      end
      exp_addr = exp_addr + `ADDR_STEP;
      last_idx = idx;
   endtask

   always @(posedge CLK_I) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         stop_with_failure($sformatf("timeout, tests not done after %0d cycles",
                                     cycle_cnt));
      end
   end

   initial begin : main_seq
      int   i;
      int   max_ack;
      int   n_burst;
      int   accepted;
      logic exp_ovf;
      rst_n       = 1'b0;
      ser_din     = 1'b0;
      ser_en      = 1'b0;
      ACK_I       = 1'b0;
      cycle_cnt   = 0;
      cycle_limit = '1;
      rng_state   = 32'h10c7_590b;
      exp_addr    = `WB_BASE_ADDR;
      last_idx    = 0;
      load_stimulus();
      max_ack = 0;
      for (i = 0; i < n_recs; i++) begin
         if (rec_ack[i] > max_ack) begin
            max_ack = rec_ack[i];
         end
      end
      cycle_limit = n_recs * (32 + MAX_GAP + max_ack + 8) + 100;
      // three reset cycles
      repeat (3) @(negedge CLK_I);
      rst_n = 1'b1;
      @(negedge CLK_I);
      check_value("CYC_O", CYC_O, 1'b0);
      check_value("STB_O", STB_O, 1'b0);
      check_value("overflow", overflow, 1'b0);
      check_value("adr_fold", adr_fold, '0);
      check_value("dat_fold", dat_fold, '0);
      // one word at a time with the master idle on arrival
      for (i = 0; i < n_recs; i++) begin
         if (!rec_burst[i]) begin
            sent_q.push_back(rec_word[i]);
            idx_q.push_back(i);
            send_word(rec_word[i]);
            serve_write();
         end
      end
      // burst with ACK_I low while the master holds one word and the fifo the rest
      n_burst  = 0;
      accepted = 0;
      for (i = 0; i < n_recs; i++) begin
         if (rec_burst[i]) begin
            n_burst = n_burst + 1;
            if (accepted < 1 + `FIFO_DEPTH) begin
               sent_q.push_back(rec_word[i]);
               idx_q.push_back(i);
               accepted = accepted + 1;
            end
            send_word(rec_word[i]);
         end
      end
      exp_ovf = (n_burst > 1 + `FIFO_DEPTH);
      // push and overflow update land two edges later
      repeat (2) @(negedge CLK_I);
      check_value("file overflow", file_ovf, exp_ovf);
      check_value("overflow", overflow, exp_ovf);
      check_value("STB_O", STB_O, (n_burst > 0));
      while (sent_q.size() > 0) begin
         serve_write();
      end
      // dropped word must never reach the bus
      repeat (QUIET) begin
         @(negedge CLK_I);
         check_value("STB_O", STB_O, 1'b0);
      end
      check_value("dat_fold.fold8", dat_fold.fold8, rec_df8[last_idx]);
      check_value("dat_fold.fold1", dat_fold.fold1, rec_df1[last_idx]);
      check_value("overflow", overflow, exp_ovf);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== bench/pinreduce_stimulus.txt ====
# tag id word ack_wait adr_fold8 adr_fold1 dat_fold8 dat_fold1 (hex for word and folds)
# tag w = single write, b = burst with ACK_I withheld, o = expected overflow (last line)
# single writes from address 0x1000
w 1 deadbeef 1 10 0 22 0
w 2 12345678 3 14 0 08 0
w 3 f00f3c03 2 18 1 c0 1
w 4 cafef00d 5 1c 0 c9 0
w 5 80000001 1 00 0 81 1
# burst of six words, master holds the first, fifo takes four
# the sixth word is dropped, its folds are for address 0x1028
b 6 11223344 2 04 0 44 0
b 7 330000cf 1 08 0 fc 1
b 8 76543210 4 0c 1 00 0
b 9 9abcdef0 3 30 1 08 0
b 10 0badcafe 2 34 0 92 0
b 11 55aa33cc 1 38 0 00 0
# overflow expected after the burst
o 1

// ==== flist.f ====
+incdir+verilog
verilog/wb_pkg.sv
verilog/harness_pkg.sv
verilog/serial_word_loader.sv
verilog/word_fifo.sv
verilog/wb_write_master.sv
verilog/xor_fold_observer.sv
verilog/pinreduce_top.sv
bench/tb_pinreduce.sv
